//--- hw/erx_pkg.sv
package erx_pkg;

   // ########################################################################
   // register file map
   // ########################################################################

   localparam int RFAW = 6;                 // register index width, addr bits 7:2

   typedef enum logic [RFAW-1:0] {
      ERX_CFG    = 6'd0,                    // remap, mmu and timer config
      ERX_OFFSET = 6'd1,                    // dynamic remap base
      ERX_GPIO   = 6'd2,                    // sampled frame/data pins
      ERX_STATUS = 6'd3                     // live + sticky status
   } erx_reg_e;

   localparam int GPIO_W        = 9;        // frame + 8 data pins
   localparam int STICKY_W      = 3;        // status bits that latch
   localparam int STATUS_W      = 16;
   localparam int REMAP_FIELD_W = 12;       // upper addr bits touched by static remap

   // config register fields
   localparam int CFG_MMU_EN_BIT = 1;
   localparam int CFG_MODE_LSB   = 2;       // 3:2
   localparam int CFG_SEL_LSB    = 4;       // 15:4
   localparam int CFG_PAT_LSB    = 16;      // 27:16
   localparam int CFG_TMR_LSB    = 28;      // 29:28

   // ########################################################################
   // remap and watchdog
   // ########################################################################

   typedef enum logic [1:0] {
      REMAP_OFF     = 2'd0,
      REMAP_STATIC  = 2'd1,
      REMAP_DYNAMIC = 2'd2,
      REMAP_RSVD    = 2'd3                  // treated as off
   } remap_mode_e;

   typedef enum logic [1:0] {
      TIMER_OFF   = 2'd0,
      TIMER_SHORT = 2'd1,
      TIMER_MED   = 2'd2,
      TIMER_LONG  = 2'd3
   } timer_cfg_e;

   localparam logic [11:0] TIMEOUT_SHORT = 12'd15;    // idle cycles per setting
   localparam logic [11:0] TIMEOUT_MED   = 12'd63;
   localparam logic [11:0] TIMEOUT_LONG  = 12'd255;

endpackage

//--- hw/ecfg_rx.sv
`timescale 1ns/1ps

module ecfg_rx
   import erx_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   // register bus
   input  logic                     mi_en,
   input  logic                     mi_we,          // full 32-bit writes only
   input  logic [14:0]              mi_addr,        // byte address
   input  logic [31:0]              mi_din,
   output logic [31:0]              mi_dout,        // valid one cycle after read
   // pins and status
   input  logic [GPIO_W-1:0]        gpio_datain,
   input  logic [STATUS_W-1:0]      rx_status,
   // config outputs, static during traffic
   output logic                     mmu_enable,
   output remap_mode_e              remap_mode,
   output logic [REMAP_FIELD_W-1:0] remap_sel,
   output logic [REMAP_FIELD_W-1:0] remap_pattern,
   output logic [31:0]              remap_base,
   output timer_cfg_e               timer_cfg
);

   logic [31:0]         cfg_reg;
   logic [31:0]         offset_reg;
   logic [GPIO_W-1:0]   gpio_reg;
   logic [STICKY_W-1:0] sticky_reg;

   logic      mi_write;
   logic      mi_read;
   erx_reg_e  reg_idx;

   // ########################################################################
   // address decode
   // ########################################################################

   assign mi_write = mi_en & mi_we;
   assign mi_read  = mi_en & ~mi_we;
   assign reg_idx  = erx_reg_e'(mi_addr[RFAW+1:2]);   // word index, low bits ignored

   // ########################################################################
   // config and offset registers
   // ########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg <= '0;
      end else if (mi_write && reg_idx == ERX_CFG) begin
         cfg_reg <= mi_din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         offset_reg <= '0;
      end else if (mi_write && reg_idx == ERX_OFFSET) begin
         offset_reg <= mi_din;
      end
   end

   // field breakout
   assign mmu_enable    = cfg_reg[CFG_MMU_EN_BIT];
   assign remap_mode    = remap_mode_e'(cfg_reg[CFG_MODE_LSB +: 2]);
   assign remap_sel     = cfg_reg[CFG_SEL_LSB +: REMAP_FIELD_W];
   assign remap_pattern = cfg_reg[CFG_PAT_LSB +: REMAP_FIELD_W];
   assign timer_cfg     = timer_cfg_e'(cfg_reg[CFG_TMR_LSB +: 2]);
   assign remap_base    = offset_reg;

   // ########################################################################
   // pin sample and sticky status
   // ########################################################################

   always_ff @(posedge clk) begin
      gpio_reg <= gpio_datain;                 // free-running sample
   end

   // timeout and error bits latch until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         sticky_reg <= '0;
      end else begin
         sticky_reg <= sticky_reg | rx_status[STICKY_W-1:0];
      end
   end

   // ########################################################################
   // readback mux, one cycle latency
   // ########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         mi_dout <= '0;
      end else if (mi_read) begin
         case (reg_idx)
            ERX_CFG:    mi_dout <= cfg_reg;
            ERX_OFFSET: mi_dout <= offset_reg;
            ERX_GPIO:   mi_dout <= {{(32-GPIO_W){1'b0}}, gpio_reg};
            ERX_STATUS: mi_dout <= {{(32-STATUS_W){1'b0}},
                                    rx_status[STATUS_W-1:STICKY_W], sticky_reg};
            default:    mi_dout <= '0;     // unmapped index
         endcase
      end else begin
         mi_dout <= '0;                    // bus idle or write
      end
   end

   // bus is shared by OR downstream, so a stale word must never linger
   a_dout_zero_when_idle: assert property (
      @(posedge clk) disable iff (reset)
      !$past(mi_read) |-> (mi_dout == 32'd0)
   );

endmodule

//--- hw/erx_remap.sv
`timescale 1ns/1ps

module erx_remap
   import erx_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   // incoming transaction
   input  logic        in_valid,
   input  logic [31:0] in_addr,
   // config from register file
   input  remap_mode_e remap_mode,
   input  logic [11:0] remap_sel,        // 1 = take pattern bit
   input  logic [11:0] remap_pattern,
   input  logic [31:0] remap_base,       // dynamic offset
   // remapped transaction, one cycle later
   output logic        out_valid,
   output logic [31:0] out_addr
);

   logic [31:0] static_addr;
   logic [31:0] dynamic_addr;
   logic [31:0] next_addr;

   // ########################################################################
   // remap rules
   // ########################################################################

   // static: bitwise mux on the top 12 address bits
   assign static_addr = {(in_addr[31:20] & ~remap_sel) | (remap_pattern & remap_sel),
                         in_addr[19:0]};

   // dynamic: plain add, carry out dropped
   assign dynamic_addr = in_addr + remap_base;

   always_comb begin
      case (remap_mode)
         REMAP_STATIC:  next_addr = static_addr;
         REMAP_DYNAMIC: next_addr = dynamic_addr;
         default:       next_addr = in_addr;   // off and reserved
      endcase
   end

   // ########################################################################
   // pipeline stage
   // ########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   // address rides along, qualified by out_valid
   always_ff @(posedge clk) begin
      out_addr <= next_addr;
   end

   // stream cannot stall, so every valid must come out exactly once
   a_valid_latency: assert property (
      @(posedge clk) disable iff (reset)
      !$past(reset) |-> (out_valid == $past(in_valid))
   );

endmodule

//--- hw/erx_timeout.sv
`timescale 1ns/1ps

module erx_timeout
   import erx_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       frame,          // link frame open
   input  logic       activity,       // transaction seen this cycle
   input  timer_cfg_e timer_cfg,
   output logic       timeout         // one-cycle pulse at end of idle period
);

   logic [11:0] idle_cnt;
   logic [11:0] limit;
   logic        idle;
   logic        hit;

   // ########################################################################
   // limit select
   // ########################################################################

   always_comb begin
      case (timer_cfg)
         TIMER_SHORT: limit = TIMEOUT_SHORT;
         TIMER_MED:   limit = TIMEOUT_MED;
         TIMER_LONG:  limit = TIMEOUT_LONG;
         default:     limit = '0;           // off, never reached since idle is low
      endcase
   end

   // counting only while frame open, quiet, timer on
   assign idle = frame & ~activity & (timer_cfg != TIMER_OFF);

   // >= covers a limit lowered mid-count
   assign hit = idle & (idle_cnt >= limit);

   // ########################################################################
   // idle counter
   // ########################################################################

   always_ff @(posedge clk) begin
      if (reset || !idle || hit) begin
         idle_cnt <= '0;                      // restart after each pulse
      end else begin
         idle_cnt <= idle_cnt + 12'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         timeout <= 1'b0;
      end else begin
         timeout <= hit;
      end
   end

   // counter restart guarantees a gap before the next pulse
   a_timeout_single: assert property (
      @(posedge clk) disable iff (reset)
      timeout |=> !timeout
   );

endmodule

//--- hw/erx_cfg_top.sv
`timescale 1ns/1ps

module erx_cfg_top
   import erx_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // register bus
   input  logic              mi_en,
   input  logic              mi_we,
   input  logic [14:0]       mi_addr,
   input  logic [31:0]       mi_din,
   output logic [31:0]       mi_dout,
   // pins and status sources
   input  logic [GPIO_W-1:0] gpio_datain,
   input  logic [12:0]       link_status,    // live, status bits 15:3
   input  logic [1:0]        rx_err,         // sticky, status bits 2:1
   input  logic              rx_frame,
   // receive transaction stream, valid only
   input  logic              rx_valid,
   input  logic [31:0]       rx_addr,
   output logic              rx_out_valid,
   output logic [31:0]       rx_out_addr,
   // config out to mmu
   output logic              mmu_enable
);

   remap_mode_e              remap_mode;
   logic [REMAP_FIELD_W-1:0] remap_sel;
   logic [REMAP_FIELD_W-1:0] remap_pattern;
   logic [31:0]              remap_base;
   timer_cfg_e               timer_cfg;
   logic                     timeout;
   logic [STATUS_W-1:0]      rx_status;

   // status word, bit 0 is the watchdog pulse
   assign rx_status = {link_status, rx_err, timeout};

   // ########################################################################
   // register file
   // ########################################################################

   ecfg_rx u_cfg (
      .clk           (clk),
      .reset         (reset),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_din        (mi_din),
      .mi_dout       (mi_dout),
      .gpio_datain   (gpio_datain),
      .rx_status     (rx_status),
      .mmu_enable    (mmu_enable),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .timer_cfg     (timer_cfg)
   );

   // ########################################################################
   // receive path units
   // ########################################################################

   erx_remap u_remap (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (rx_valid),
      .in_addr       (rx_addr),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .out_valid     (rx_out_valid),
      .out_addr      (rx_out_addr)
   );

   erx_timeout u_timeout (
      .clk       (clk),
      .reset     (reset),
      .frame     (rx_frame),
      .activity  (rx_valid),            // any transaction resets the idle count
      .timer_cfg (timer_cfg),
      .timeout   (timeout)
   );

endmodule

//--- test/tb_erx.sv
`timescale 1ns/1ps

module tb_erx
   import erx_pkg::*;
();

   localparam int CYCLE_LIMIT = 3000;   // full run is well under 1000 cycles

   logic        clk;
   logic        reset;
   logic        mi_en;
   logic        mi_we;
   logic [14:0] mi_addr;
   logic [31:0] mi_din;
   logic [31:0] mi_dout;
   logic [8:0]  gpio_datain;
   logic [12:0] link_status;
   logic [1:0]  rx_err;
   logic        rx_frame;
   logic        rx_valid;
   logic [31:0] rx_addr;
   logic        rx_out_valid;
   logic [31:0] rx_out_addr;
   logic        mmu_enable;

   // reference model state
   logic [31:0] sh_cfg;
   logic [31:0] sh_off;
   logic [1:0]  sh_err;                 // sticky error bits 2:1
   logic        wd_clear;               // watchdog provably idle since reset
   logic [8:0]  gpio_q;
   logic [31:0] exp_dout;
   logic [31:0] exp_mask;
   logic        exp_valid;
   logic [31:0] exp_addr;
   int          cycle_cnt = 0;
   logic        found;
   logic [31:0] rd_data;

   erx_cfg_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ########################################################################
   // reference model
   // ########################################################################

   function automatic logic [31:0] remap_expect(input logic [31:0] addr,
                                                input logic [31:0] cfg,
                                                input logic [31:0] base);
      logic [31:0] res;
      res = addr;
      case (cfg[3:2])
         2'd1: begin                     // static mode selects per bit on 31:20
            for (int b = 0; b < 12; b++) begin
               if (cfg[4+b])
                  res[20+b] = cfg[16+b];
            end
         end
         2'd2: res = addr + base;        // dynamic mode wraps at 2**32
         default: res = addr;            // off and reserved
      endcase
      return res;
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         sh_cfg    <= '0;
         sh_off    <= '0;
         sh_err    <= '0;
         wd_clear  <= 1'b1;
         exp_dout  <= '0;
         exp_mask  <= '1;
         exp_valid <= 1'b0;
      end else begin
         exp_mask <= '1;
         if (mi_en && !mi_we) begin
            case (mi_addr[7:2])
               ERX_CFG:    exp_dout <= sh_cfg;
               ERX_OFFSET: exp_dout <= sh_off;
               ERX_GPIO:   exp_dout <= {23'd0, gpio_q};
               ERX_STATUS: begin
                  exp_dout <= {16'd0, link_status, sh_err, 1'b0};
                  exp_mask <= wd_clear ? 32'hffff_ffff : 32'hffff_fffe;  // bit 0 unknown once armed
               end
               default:    exp_dout <= '0;
            endcase
         end else begin
            exp_dout <= '0;
         end
         if (mi_en && mi_we && mi_addr[7:2] == ERX_CFG)
            sh_cfg <= mi_din;
         if (mi_en && mi_we && mi_addr[7:2] == ERX_OFFSET)
            sh_off <= mi_din;
         sh_err <= sh_err | rx_err;
         // counter can only run with frame open and timer on
         if (sh_cfg[CFG_TMR_LSB +: 2] != 2'd0 && rx_frame)
            wd_clear <= 1'b0;
         exp_valid <= rx_valid;
         exp_addr  <= remap_expect(rx_addr, sh_cfg, sh_off);
      end
      gpio_q <= gpio_datain;             // pins sampled every cycle
   end

   // ########################################################################
   // checks
   // ########################################################################

   check_dout: assert property (@(posedge clk) disable iff (reset)
      (mi_dout & exp_mask) == (exp_dout & exp_mask))
   else begin
      $display("FAILED mi_dout: got %h expected %h (mask %h)",
               $sampled(mi_dout), $sampled(exp_dout), $sampled(exp_mask));
      $display("TESTBENCH FAILED");
      $fatal(1, "readback mismatch");
   end

   check_out_valid: assert property (@(posedge clk) disable iff (reset)
      rx_out_valid == exp_valid)
   else begin
      $display("FAILED rx_out_valid: got %h expected %h",
               $sampled(rx_out_valid), $sampled(exp_valid));
      $display("TESTBENCH FAILED");
      $fatal(1, "valid mismatch");
   end

   check_out_addr: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> rx_out_addr == exp_addr)
   else begin
      $display("FAILED rx_out_addr: got %h expected %h",
               $sampled(rx_out_addr), $sampled(exp_addr));
      $display("TESTBENCH FAILED");
      $fatal(1, "remap mismatch");
   end

   check_mmu: assert property (@(posedge clk) disable iff (reset)
      mmu_enable == sh_cfg[CFG_MMU_EN_BIT])
   else begin
      $display("FAILED mmu_enable: got %h expected %h",
               $sampled(mmu_enable), $sampled(sh_cfg[CFG_MMU_EN_BIT]));
      $display("TESTBENCH FAILED");
      $fatal(1, "mmu enable mismatch");
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TESTBENCH FAILED");
         $fatal(1, "cycle limit");
      end
   end

   // ########################################################################
   // stimulus tasks
   // ########################################################################

   // one bus cycle with random bits outside 7:2
   task automatic access(input logic en, input logic we, input logic [5:0] idx,
                         input logic [31:0] data);
      @(posedge clk);
      mi_en   <= en;
      mi_we   <= we;
      mi_addr <= {7'($urandom), idx, 2'($urandom)};
      mi_din  <= data;
   endtask

   task automatic write_reg(input logic [5:0] idx, input logic [31:0] data);
      access(1'b1, 1'b1, idx, data);
   endtask

   task automatic read_reg(input logic [5:0] idx);
      access(1'b1, 1'b0, idx, 32'd0);
   endtask

   task automatic bus_idle();
      access(1'b0, 1'b0, 6'd0, 32'd0);
   endtask

   // read and hand back the word sampled mid-cycle
   task automatic read_value(input logic [5:0] idx, output logic [31:0] data);
      read_reg(idx);
      bus_idle();
      @(negedge clk);
      data = mi_dout;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset    <= 1'b1;
      rx_valid <= 1'b0;
      rx_frame <= 1'b0;
      wait_cycles(2);
      reset <= 1'b0;
   endtask

   // random select/pattern/base with the timer kept off
   task automatic configure_remap(input logic [1:0] mode);
      logic [31:0] cfg;
      cfg = $urandom;
      cfg[CFG_TMR_LSB +: 2]  = 2'd0;
      cfg[CFG_MODE_LSB +: 2] = mode;
      write_reg(ERX_CFG, cfg);
      write_reg(ERX_OFFSET, $urandom);
      bus_idle();
   endtask

   task automatic run_stream(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         rx_valid <= 1'b1;               // back to back
         rx_addr  <= $urandom;
      end
      @(posedge clk);
      rx_valid <= 1'b0;
   endtask

   // ########################################################################
   // test sequence
   // ########################################################################

   initial begin
      logic [31:0] cfg;
      void'($urandom(32'hfa00_ea68));
      reset       = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      gpio_datain = '0;
      link_status = 13'($urandom);
      rx_err      = '0;
      rx_frame    = 1'b0;
      rx_valid    = 1'b0;
      rx_addr     = '0;
      wait_cycles(2);
      reset <= 1'b0;

      // reset values
      read_reg(ERX_CFG);
      read_reg(ERX_OFFSET);
      read_reg(ERX_GPIO);
      read_reg(ERX_STATUS);
      bus_idle();

      // config and offset readback while check_mmu tracks mmu_enable
      repeat (12) begin
         write_reg(ERX_CFG, $urandom);
         read_reg(ERX_CFG);
         write_reg(ERX_OFFSET, $urandom);
         read_reg(ERX_OFFSET);
      end
      read_reg(6'd5);                    // unmapped
      read_reg(6'd63);
      bus_idle();
      wait_cycles(2);
      read_reg(ERX_CFG);
      bus_idle();

      // gpio and status
      @(posedge clk);
      gpio_datain <= 9'($urandom);
      link_status <= 13'($urandom);
      wait_cycles(2);
      read_reg(ERX_GPIO);
      read_reg(ERX_STATUS);
      @(posedge clk);
      rx_err <= 2'b10;                   // single-cycle pulse
      @(posedge clk);
      rx_err <= 2'b00;
      wait_cycles(3);
      read_reg(ERX_STATUS);
      read_reg(ERX_STATUS);
      @(posedge clk);
      rx_err <= 2'b01;
      @(posedge clk);
      rx_err <= 2'b00;
      read_reg(ERX_STATUS);
      bus_idle();

      // every remap mode twice
      for (int m = 0; m < 8; m++) begin
         configure_remap(2'(m));
         run_stream(30);
      end

      // short watchdog timer with an open idle frame
      cfg = '0;
      cfg[CFG_TMR_LSB +: 2] = TIMER_SHORT;
      write_reg(ERX_CFG, cfg);
      bus_idle();
      @(posedge clk);
      rx_frame <= 1'b1;
      found = 1'b0;
      for (int i = 0; i < 40 && !found; i++) begin
         read_value(ERX_STATUS, rd_data);
         if (rd_data[0])
            found = 1'b1;
      end
      check_watchdog: assert (found)
      else begin
         $display("watchdog timeout never reached status bit 0");
         $display("TESTBENCH FAILED");
         $fatal(1, "watchdog silent");
      end
      @(posedge clk);
      rx_frame <= 1'b0;

      // timer off after reset keeps bit 0 clear
      apply_reset();
      @(posedge clk);
      rx_frame <= 1'b1;
      repeat (30) begin
         wait_cycles(8);
         read_reg(ERX_STATUS);
         bus_idle();
      end
      @(posedge clk);
      rx_frame <= 1'b0;
      wait_cycles(3);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- build.f
hw/erx_pkg.sv
hw/ecfg_rx.sv
hw/erx_remap.sv
hw/erx_timeout.sv
hw/erx_cfg_top.sv
test/tb_erx.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_erx
RTL_TOP   ?= erx_cfg_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

RTL_SRCS  := hw/erx_pkg.sv hw/ecfg_rx.sv hw/erx_remap.sv hw/erx_timeout.sv hw/erx_cfg_top.sv
TB_SRCS   := test/tb_erx.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --assert $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
